//--- tb.f
+incdir+hw
+incdir+verification
hw/decoderPkg.sv
hw/rTypeDecoder.sv
hw/immMemDecoder.sv
hw/flowDecoder.sv
hw/controlRegister.sv
hw/controlUnit.sv
verification/tbControlUnit.sv

//--- verification/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Expected control fields; the all-zero value is the inactive one
typedef struct packed {
	logic reservedInstr;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic reverse;
	logic syscall;
	regDstT regDst;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	changeTypeT changeType;
	memToRegT memToReg;
	loadTypeT loadType;
	storeTypeT storeType;
} ctrlFieldsT;

logic [31:0] lcgState;

function automatic logic [31:0] nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return {8'h00, lcgState[31:8]}; // Drop the weak low bits
endfunction

function automatic ctrlFieldsT decodeModel(
	input logic [`OPCODE_WIDTH-1:0] op,
	input logic [`FUNCT_WIDTH-1:0] fn,
	input logic [`REG_ADDR_WIDTH-1:0] rtField
);
	ctrlFieldsT c;
	c = '0;
	case (op)
		opRType:
		begin
			if (fn == fnJr || fn == fnJalr)
			begin
				c.changeType = chgJump;
				c.aluSrcA = srcARs;
				c.aluSrcB = srcBZero;
				c.aluOp = aluAdd;
				if (fn == fnJalr)
				begin
					c.regWrite = 1'b1;
					c.regDst = dstRd;
					c.memToReg = wbPcLink;
				end
			end
			else if (fn == fnSyscall)
				c.syscall = 1'b1;
			else
			begin
				case (fn)
					fnAdd: c.aluOp = aluAdd;
					fnAddu: c.aluOp = aluAddu;
					fnSub: c.aluOp = aluSub;
					fnSubu: c.aluOp = aluSubu;
					fnAnd: c.aluOp = aluAnd;
					fnOr: c.aluOp = aluOr;
					fnXor: c.aluOp = aluXor;
					fnNor: c.aluOp = aluNor;
					fnSlt: c.aluOp = aluSlt;
					fnSltu: c.aluOp = aluSltu;
					fnSll: c.aluOp = aluSll;
					fnSllv: c.aluOp = aluSllv;
					fnSra: c.aluOp = aluSra;
					fnSrav: c.aluOp = aluSrav;
					fnSrl: c.aluOp = aluSrl;
					fnSrlv: c.aluOp = aluSrlv;
					default: c.reservedInstr = 1'b1;
				endcase
				if (!c.reservedInstr)
				begin
					c.regWrite = 1'b1;
					c.regDst = dstRd;
					// Constant shifts take the shamt field
					c.aluSrcA = (fn == fnSll || fn == fnSra || fn == fnSrl) ? srcAShamt : srcARs;
					c.aluSrcB = srcBRt;
				end
			end
		end
		opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opSltiu, opLui:
		begin
			c.regWrite = 1'b1;
			c.regDst = dstRt;
			c.aluSrcA = srcARs;
			c.aluSrcB = (op == opAddi || op == opAddiu || op == opSlti) ? srcBSignImm : srcBZeroImm;
			case (op)
				opAddi: c.aluOp = aluAdd;
				opAddiu: c.aluOp = aluAddu;
				opSlti: c.aluOp = aluSlt;
				opAndi: c.aluOp = aluAnd;
				opOri: c.aluOp = aluOr;
				opXori: c.aluOp = aluXor;
				opSltiu: c.aluOp = aluSltu;
				default:
				begin
					c.aluSrcA = srcANone; // lui needs no register operand
					c.aluOp = aluLui;
				end
			endcase
		end
		opLb, opLbu, opLh, opLhu, opLw:
		begin
			c.regWrite = 1'b1;
			c.regDst = dstRt;
			c.aluSrcA = srcARs;
			c.aluSrcB = srcBSignImm;
			c.aluOp = aluAdd;
			c.memRead = 1'b1;
			c.memToReg = wbMem;
			case (op)
				opLb: c.loadType = ldByte;
				opLbu: c.loadType = ldByteU;
				opLh: c.loadType = ldHalf;
				opLhu: c.loadType = ldHalfU;
				default: c.loadType = ldWord;
			endcase
		end
		opSb, opSh, opSw:
		begin
			c.aluSrcA = srcARs;
			c.aluSrcB = srcBSignImm;
			c.aluOp = aluAdd;
			c.memWrite = 1'b1;
			c.storeType = (op == opSb) ? stByte : (op == opSh) ? stHalf : stWord;
		end
		opBeq, opBne:
		begin
			c.changeType = chgBranch;
			c.aluSrcA = srcARs;
			c.aluSrcB = srcBRt;
			c.aluOp = aluSub;
			c.reverse = (op == opBne);
		end
		opBgtz, opBlez:
		begin
			c.changeType = chgBranch;
			c.aluSrcA = srcARs;
			c.aluSrcB = srcBZero;
			c.aluOp = aluSgt;
			c.reverse = (op == opBgtz);
		end
		opRegImm:
		begin
			if (rtField == 0 || rtField == 1) // bltz or bgez
			begin
				c.changeType = chgBranch;
				c.aluSrcA = srcARs;
				c.aluSrcB = srcBZero;
				c.aluOp = aluSlt;
				c.reverse = (rtField == 0);
			end
			else
				c.reservedInstr = 1'b1;
		end
		opJ, opJal:
		begin
			c.changeType = chgJump;
			c.aluSrcA = srcAPc;
			c.aluSrcB = srcBJumpTarget;
			c.aluOp = aluJump;
			if (op == opJal)
			begin
				c.regWrite = 1'b1;
				c.regDst = dstLink;
				c.memToReg = wbPcLink;
			end
		end
		default: c.reservedInstr = 1'b1;
	endcase
	return c;
endfunction

`endif

//--- verification/tbControlUnit.sv
`timescale 1ns/1ps
`include "decoderSettings.svh"

module tbControlUnit import decoderPkg::*;;

	localparam int NUM_STROBES = 3000;
	localparam int MAX_CYCLES = 10000; // Cap on the issue loop

	logic clk, reset, instrValid;
	opcodeT opcode;
	functT funct;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic ctrlValid, regWrite, memRead, memWrite, reverse, syscall, reservedInstr;
	regDstT regDst;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	changeTypeT changeType;
	memToRegT memToReg;
	loadTypeT loadType;
	storeTypeT storeType;

	`include "controlModel.svh"

	opcodeT legalOps [0:23] = '{opRType, opRegImm, opJ, opJal, opBeq, opBne, opBlez, opBgtz,
		opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui,
		opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
	functT legalFns [0:18] = '{fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr,
		fnSyscall, fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};

	ctrlFieldsT expFields; // One-entry expected register
	logic expValid;
	int strobeCount, cycleCount;

	controlUnit dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
			failRun($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act));
	endtask

	task automatic compareOutputs();
		checkField("ctrlValid", expValid, ctrlValid);
		checkField("reservedInstr", expFields.reservedInstr, reservedInstr);
		checkField("regWrite", expFields.regWrite, regWrite);
		checkField("memRead", expFields.memRead, memRead);
		checkField("memWrite", expFields.memWrite, memWrite);
		checkField("reverse", expFields.reverse, reverse);
		checkField("syscall", expFields.syscall, syscall);
		checkField("regDst", expFields.regDst, regDst);
		checkField("aluSrcA", expFields.aluSrcA, aluSrcA);
		checkField("aluSrcB", expFields.aluSrcB, aluSrcB);
		checkField("aluOp", expFields.aluOp, aluOp);
		checkField("changeType", expFields.changeType, changeType);
		checkField("memToReg", expFields.memToReg, memToReg);
		checkField("loadType", expFields.loadType, loadType);
		checkField("storeType", expFields.storeType, storeType);
	endtask

	// Fields change every cycle, so idle cycles also test that the outputs hold
	task automatic driveRandom();
		logic [31:0] pick;
		pick = nextRand();
		if (pick % 100 < 85)
			opcode = legalOps[nextRand() % 24];
		else
		begin
			pick = nextRand();
			opcode = opcodeT'(pick[5:0]);
		end
		pick = nextRand();
		if (pick % 100 < 85)
			funct = legalFns[nextRand() % 19];
		else
		begin
			pick = nextRand();
			funct = functT'(pick[5:0]);
		end
		pick = nextRand() % 4;
		rt = pick[`REG_ADDR_WIDTH-1:0];
		instrValid = (nextRand() % 100) < 70;
		expValid = instrValid;
		if (instrValid)
		begin
			expFields = decodeModel(opcode, funct, rt);
			strobeCount++;
		end
	endtask

	initial
	begin
		reset = 1'b0;
		instrValid = 1'b0;
		opcode = opRType;
		funct = fnSll;
		rt = '0;
		lcgState = 32'hc435_9a12;
		expValid = 1'b0;
		expFields = '0;
		strobeCount = 0;
		cycleCount = 0;
		repeat (16)
		begin
			@(negedge clk);
			compareOutputs();
		end
		reset = 1'b1;
		while (strobeCount < NUM_STROBES && cycleCount < MAX_CYCLES)
		begin
			@(negedge clk);
			compareOutputs();
			driveRandom();
			cycleCount++;
		end
		if (strobeCount < NUM_STROBES)
			failRun("Timed out before all instructions were issued to the decoder");
		else
		begin
			repeat (4) // Last result, then idle cycles
			begin
				@(negedge clk);
				compareOutputs();
				instrValid = 1'b0;
				expValid = 1'b0;
			end
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ps
`include "decoderSettings.svh"

module controlUnit import decoderPkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input opcodeT opcode,
	input functT funct,
	input logic [`REG_ADDR_WIDTH-1:0] rt,
	output logic ctrlValid, regWrite, memRead, memWrite, reverse, syscall, reservedInstr,
	output regDstT regDst,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output changeTypeT changeType,
	output memToRegT memToReg,
	output loadTypeT loadType,
	output storeTypeT storeType
);

	logic rtHit, rtIllegal, rtRegWrite, rtSyscall;
	logic imHit, imRegWrite, imMemRead, imMemWrite;
	logic flHit, flIllegal, flRegWrite, flReverse;
	regDstT rtRegDst, imRegDst, flRegDst;
	aluSrcAT rtAluSrcA, imAluSrcA, flAluSrcA;
	aluSrcBT rtAluSrcB, imAluSrcB, flAluSrcB;
	aluOpT rtAluOp, imAluOp, flAluOp;
	changeTypeT rtChangeType, flChangeType;
	memToRegT rtMemToReg, imMemToReg, flMemToReg;
	loadTypeT imLoadType;
	storeTypeT imStoreType;

	rTypeDecoder rTypeDec0 (
		.opcode(opcode), .funct(funct), .hit(rtHit), .illegal(rtIllegal),
		.regWrite(rtRegWrite), .syscall(rtSyscall), .regDst(rtRegDst),
		.aluSrcA(rtAluSrcA), .aluSrcB(rtAluSrcB), .aluOp(rtAluOp),
		.changeType(rtChangeType), .memToReg(rtMemToReg)
	);

	immMemDecoder immMemDec0 (
		.opcode(opcode), .hit(imHit), .regWrite(imRegWrite), .memRead(imMemRead),
		.memWrite(imMemWrite), .regDst(imRegDst), .aluSrcA(imAluSrcA),
		.aluSrcB(imAluSrcB), .aluOp(imAluOp), .memToReg(imMemToReg),
		.loadType(imLoadType), .storeType(imStoreType)
	);

	flowDecoder flowDec0 (
		.opcode(opcode), .rt(rt), .hit(flHit), .illegal(flIllegal),
		.regWrite(flRegWrite), .reverse(flReverse), .regDst(flRegDst),
		.aluSrcA(flAluSrcA), .aluSrcB(flAluSrcB), .aluOp(flAluOp),
		.changeType(flChangeType), .memToReg(flMemToReg)
	);

	controlRegister ctrlReg0 (
		.clk(clk), .reset(reset), .instrValid(instrValid),
		.rtHit(rtHit), .rtIllegal(rtIllegal), .rtRegWrite(rtRegWrite), .rtSyscall(rtSyscall),
		.rtRegDst(rtRegDst), .rtAluSrcA(rtAluSrcA), .rtAluSrcB(rtAluSrcB), .rtAluOp(rtAluOp),
		.rtChangeType(rtChangeType), .rtMemToReg(rtMemToReg),
		.imHit(imHit), .imRegWrite(imRegWrite), .imMemRead(imMemRead), .imMemWrite(imMemWrite),
		.imRegDst(imRegDst), .imAluSrcA(imAluSrcA), .imAluSrcB(imAluSrcB), .imAluOp(imAluOp),
		.imMemToReg(imMemToReg), .imLoadType(imLoadType), .imStoreType(imStoreType),
		.flHit(flHit), .flIllegal(flIllegal), .flRegWrite(flRegWrite), .flReverse(flReverse),
		.flRegDst(flRegDst), .flAluSrcA(flAluSrcA), .flAluSrcB(flAluSrcB), .flAluOp(flAluOp),
		.flChangeType(flChangeType), .flMemToReg(flMemToReg),
		.ctrlValid(ctrlValid), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
		.reverse(reverse), .syscall(syscall), .reservedInstr(reservedInstr),
		.regDst(regDst), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.changeType(changeType), .memToReg(memToReg), .loadType(loadType),
		.storeType(storeType)
	);

endmodule

//--- hw/controlRegister.sv
`timescale 1ns/1ps

module controlRegister import decoderPkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic rtHit, rtIllegal, rtRegWrite, rtSyscall,
	input regDstT rtRegDst,
	input aluSrcAT rtAluSrcA,
	input aluSrcBT rtAluSrcB,
	input aluOpT rtAluOp,
	input changeTypeT rtChangeType,
	input memToRegT rtMemToReg,
	input logic imHit, imRegWrite, imMemRead, imMemWrite,
	input regDstT imRegDst,
	input aluSrcAT imAluSrcA,
	input aluSrcBT imAluSrcB,
	input aluOpT imAluOp,
	input memToRegT imMemToReg,
	input loadTypeT imLoadType,
	input storeTypeT imStoreType,
	input logic flHit, flIllegal, flRegWrite, flReverse,
	input regDstT flRegDst,
	input aluSrcAT flAluSrcA,
	input aluSrcBT flAluSrcB,
	input aluOpT flAluOp,
	input changeTypeT flChangeType,
	input memToRegT flMemToReg,
	output logic ctrlValid, regWrite, memRead, memWrite, reverse, syscall, reservedInstr,
	output regDstT regDst,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output changeTypeT changeType,
	output memToRegT memToReg,
	output loadTypeT loadType,
	output storeTypeT storeType
);

	logic rtSel, imSel, flSel, noneSel;

	// A hitting decoder that flags the word illegal loses the selection
	assign rtSel = rtHit && !rtIllegal;
	assign imSel = imHit;
	assign flSel = flHit && !flIllegal;
	assign noneSel = !(rtSel || imSel || flSel);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			ctrlValid <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			reverse <= 1'b0;
			syscall <= 1'b0;
			reservedInstr <= 1'b0;
			regDst <= dstRt;
			aluSrcA <= srcANone;
			aluSrcB <= srcBRt;
			aluOp <= aluNop;
			changeType <= chgSequence;
			memToReg <= wbAlu;
			loadType <= ldNone;
			storeType <= stNone;
		end
		else
		begin
			ctrlValid <= instrValid;
			if (instrValid) // Fields hold between strobes
			begin
				regWrite <= (rtSel && rtRegWrite) || (imSel && imRegWrite) || (flSel && flRegWrite);
				memRead <= imSel && imMemRead;
				memWrite <= imSel && imMemWrite;
				reverse <= flSel && flReverse;
				syscall <= rtSel && rtSyscall;
				reservedInstr <= noneSel;
				regDst <= rtSel ? rtRegDst : imSel ? imRegDst : flSel ? flRegDst : dstRt;
				aluSrcA <= rtSel ? rtAluSrcA : imSel ? imAluSrcA : flSel ? flAluSrcA : srcANone;
				aluSrcB <= rtSel ? rtAluSrcB : imSel ? imAluSrcB : flSel ? flAluSrcB : srcBRt;
				aluOp <= rtSel ? rtAluOp : imSel ? imAluOp : flSel ? flAluOp : aluNop;
				changeType <= rtSel ? rtChangeType : flSel ? flChangeType : chgSequence;
				memToReg <= rtSel ? rtMemToReg : imSel ? imMemToReg : flSel ? flMemToReg : wbAlu;
				loadType <= imSel ? imLoadType : ldNone;
				storeType <= imSel ? imStoreType : stNone;
			end
		end
	end

	// Opcode classes of the three decoders never overlap
	oneHit: assert property (@(posedge clk) disable iff (!reset)
		instrValid |-> $onehot0({rtHit, imHit, flHit}))
		else $error("More than one decoder hit on the same opcode");

	noReadWrite: assert property (@(posedge clk) disable iff (!reset)
		ctrlValid |-> !(memRead && memWrite))
		else $error("memRead and memWrite both set");

	reservedQuiet: assert property (@(posedge clk) disable iff (!reset)
		ctrlValid && reservedInstr |-> !regWrite && !memWrite)
		else $error("Reserved instruction with a state write enabled");

endmodule

//--- hw/flowDecoder.sv
`timescale 1ns/1ps
`include "decoderSettings.svh"

module flowDecoder import decoderPkg::*;
(
	input opcodeT opcode,
	input logic [`REG_ADDR_WIDTH-1:0] rt,
	output logic hit,
	output logic illegal,
	output logic regWrite,
	output logic reverse,
	output regDstT regDst,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output changeTypeT changeType,
	output memToRegT memToReg
);

	// regimm sub-codes carried in rt
	localparam logic [`REG_ADDR_WIDTH-1:0] rtBltz = 0;
	localparam logic [`REG_ADDR_WIDTH-1:0] rtBgez = 1;

	always_comb
	begin
		hit = 1'b1;
		illegal = 1'b0;
		regWrite = 1'b0;
		reverse = 1'b0;
		regDst = dstRt;
		aluSrcA = srcANone;
		aluSrcB = srcBRt;
		aluOp = aluNop;
		changeType = chgSequence;
		memToReg = wbAlu;
		case (opcode)
			opBeq, opBne:
			begin
				changeType = chgBranch;
				aluSrcA = srcARs;
				aluOp = aluSub; // Taken on zero difference
				reverse = (opcode == opBne);
			end
			opBgtz, opBlez:
			begin
				changeType = chgBranch;
				aluSrcA = srcARs;
				aluSrcB = srcBZero;
				aluOp = aluSgt;
				reverse = (opcode == opBgtz);
			end
			opRegImm:
			begin
				if ((rt == rtBltz) || (rt == rtBgez))
				begin
					changeType = chgBranch;
					aluSrcA = srcARs;
					aluSrcB = srcBZero;
					aluOp = aluSlt;
					reverse = (rt == rtBltz);
				end
				else
					illegal = 1'b1;
			end
			opJ, opJal:
			begin
				changeType = chgJump;
				aluSrcA = srcAPc;
				aluSrcB = srcBJumpTarget;
				aluOp = aluJump;
				if (opcode == opJal)
				begin
					regWrite = 1'b1;
					regDst = dstLink;
					memToReg = wbPcLink;
				end
			end
			default: hit = 1'b0;
		endcase
	end

endmodule

//--- hw/immMemDecoder.sv
`timescale 1ns/1ps

module immMemDecoder import decoderPkg::*;
(
	input opcodeT opcode,
	output logic hit,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output regDstT regDst,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output memToRegT memToReg,
	output loadTypeT loadType,
	output storeTypeT storeType
);

	always_comb
	begin
		hit = 1'b1;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regDst = dstRt;
		aluSrcA = srcARs;
		aluSrcB = srcBSignImm;
		aluOp = aluAdd; // Address add for loads and stores
		memToReg = wbAlu;
		case (opcode)
			opAddi: regWrite = 1'b1;
			opAddiu:
			begin
				regWrite = 1'b1;
				aluOp = aluAddu;
			end
			opSlti:
			begin
				regWrite = 1'b1;
				aluOp = aluSlt;
			end
			opAndi, opOri, opXori, opSltiu:
			begin
				regWrite = 1'b1;
				aluSrcB = srcBZeroImm; // Logical ops zero-extend
			end
			opLui:
			begin
				regWrite = 1'b1;
				aluSrcA = srcANone;
				aluSrcB = srcBZeroImm;
				aluOp = aluLui;
			end
			opLb, opLbu, opLh, opLhu, opLw:
			begin
				regWrite = 1'b1;
				memRead = 1'b1;
				memToReg = wbMem;
			end
			opSb, opSh, opSw: memWrite = 1'b1;
			default:
			begin
				hit = 1'b0;
				aluSrcA = srcANone;
				aluSrcB = srcBRt;
				aluOp = aluNop;
			end
		endcase
		case (opcode)
			opAndi: aluOp = aluAnd;
			opOri: aluOp = aluOr;
			opXori: aluOp = aluXor;
			opSltiu: aluOp = aluSltu;
			default: ;
		endcase
	end

	always_comb
	begin
		case (opcode)
			opLb: loadType = ldByte;
			opLbu: loadType = ldByteU;
			opLh: loadType = ldHalf;
			opLhu: loadType = ldHalfU;
			opLw: loadType = ldWord;
			default: loadType = ldNone;
		endcase
		case (opcode)
			opSb: storeType = stByte;
			opSh: storeType = stHalf;
			opSw: storeType = stWord;
			default: storeType = stNone;
		endcase
	end

endmodule

//--- hw/rTypeDecoder.sv
`timescale 1ns/1ps

module rTypeDecoder import decoderPkg::*;
(
	input opcodeT opcode,
	input functT funct,
	output logic hit,
	output logic illegal,
	output logic regWrite,
	output logic syscall,
	output regDstT regDst,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output changeTypeT changeType,
	output memToRegT memToReg
);

	assign hit = (opcode == opRType);

	always_comb
	begin
		illegal = 1'b0;
		regWrite = 1'b0;
		syscall = 1'b0;
		regDst = dstRt;
		aluSrcA = srcANone;
		aluSrcB = srcBRt;
		changeType = chgSequence;
		memToReg = wbAlu;
		case (funct)
			fnSll, fnSra, fnSrl:
			begin
				regWrite = 1'b1;
				regDst = dstRd;
				aluSrcA = srcAShamt; // Shift amount from the instruction
			end
			fnSllv, fnSrav, fnSrlv, fnAdd, fnAddu, fnSub, fnSubu,
			fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu:
			begin
				regWrite = 1'b1;
				regDst = dstRd;
				aluSrcA = srcARs;
			end
			fnJr, fnJalr:
			begin
				changeType = chgJump;
				aluSrcA = srcARs;
				aluSrcB = srcBZero; // Target is rs + 0
				if (funct == fnJalr)
				begin
					regWrite = 1'b1;
					regDst = dstRd;
					memToReg = wbPcLink;
				end
			end
			fnSyscall: syscall = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	always_comb
	begin
		case (funct)
			fnAdd, fnJr, fnJalr: aluOp = aluAdd;
			fnAddu: aluOp = aluAddu;
			fnSub: aluOp = aluSub;
			fnSubu: aluOp = aluSubu;
			fnAnd: aluOp = aluAnd;
			fnOr: aluOp = aluOr;
			fnXor: aluOp = aluXor;
			fnNor: aluOp = aluNor;
			fnSlt: aluOp = aluSlt;
			fnSltu: aluOp = aluSltu;
			fnSll: aluOp = aluSll;
			fnSllv: aluOp = aluSllv;
			fnSra: aluOp = aluSra;
			fnSrav: aluOp = aluSrav;
			fnSrl: aluOp = aluSrl;
			fnSrlv: aluOp = aluSrlv;
			default: aluOp = aluNop;
		endcase
	end

endmodule

//--- hw/decoderPkg.sv
`include "decoderSettings.svh"

package decoderPkg;

	// Primary opcode field, bits 31:26
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opRType = 0,
		opRegImm = 1,
		opJ = 2,
		opJal = 3,
		opBeq = 4,
		opBne = 5,
		opBlez = 6,
		opBgtz = 7,
		opAddi = 8,
		opAddiu = 9,
		opSlti = 10,
		opSltiu = 11,
		opAndi = 12,
		opOri = 13,
		opXori = 14,
		opLui = 15,
		opLb = 32,
		opLh = 33,
		opLw = 35,
		opLbu = 36,
		opLhu = 37,
		opSb = 40,
		opSh = 41,
		opSw = 43
	} opcodeT;

	// Funct field of opcode 0
	typedef enum logic [`FUNCT_WIDTH-1:0] {
		fnSll = 0,
		fnSrl = 2,
		fnSra = 3,
		fnSllv = 4,
		fnSrlv = 6,
		fnSrav = 7,
		fnJr = 8,
		fnJalr = 9,
		fnSyscall = 12,
		fnAdd = 32,
		fnAddu = 33,
		fnSub = 34,
		fnSubu = 35,
		fnAnd = 36,
		fnOr = 37,
		fnXor = 38,
		fnNor = 39,
		fnSlt = 42,
		fnSltu = 43
	} functT;

	typedef enum logic [`ALUOP_WIDTH-1:0] {
		aluNop, aluAdd, aluAddu, aluSub, aluSubu,
		aluAnd, aluOr, aluXor, aluNor, aluSlt,
		aluSltu, aluSgt, aluSll, aluSllv, aluSra,
		aluSrav, aluSrl, aluSrlv, aluLui, aluJump
	} aluOpT;

	typedef enum logic [1:0] {srcANone, srcARs, srcAShamt, srcAPc} aluSrcAT;

	typedef enum logic [2:0] {
		srcBRt = 0,
		srcBSignImm = 2,
		srcBZeroImm = 4,
		srcBZero = 5,
		srcBJumpTarget = 6
	} aluSrcBT;

	typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstT;

	// Write-back source
	typedef enum logic [1:0] {wbAlu, wbMem, wbPcLink} memToRegT;

	typedef enum logic [1:0] {chgSequence, chgBranch, chgJump} changeTypeT;

	typedef enum logic [2:0] {ldNone, ldByte, ldByteU, ldHalf, ldHalfU, ldWord} loadTypeT;

	typedef enum logic [1:0] {stNone, stByte, stHalf, stWord} storeTypeT;

endpackage

//--- hw/decoderSettings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// Instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define REG_ADDR_WIDTH 5

`define ALUOP_WIDTH 6

// Register written by jal
`define LINK_REG 31

`endif
